// File: verilog/rename_defs.svh
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// Slots handled per decode group
`define PIPE_WIDTH  2
// Architectural integer registers
`define ARCH_REGS   32
// Reorder buffer depth, one tag per entry
`define ROB_ENTRIES 16
// Data path width
`define XLEN        32
// Register index width, log2 of ARCH_REGS
`define REG_W       5
// Tag width, log2 of ROB_ENTRIES
`define TAG_W       4

`endif

// File: verilog/rename_pkg.sv
`include "rename_defs.svh"

package rename_pkg;

    // Operand word, a plain value or a producer tag
    // The owning source's renamed flag picks the view
    typedef union packed {
        logic [`XLEN-1:0] value;
        struct packed {
            logic [`XLEN-`TAG_W-1:0] pad;
            logic [`TAG_W-1:0]       tag;
        } tag_view;
    } operand_u;

    // One register source of an instruction
    typedef struct packed {
        logic [`REG_W-1:0] reg_idx;
        logic              renamed;
        operand_u          operand;
    } source_t;

    typedef struct packed {
        logic              valid;
        logic [`XLEN-1:0]  pc;
        logic [`REG_W-1:0] rd;
        logic              has_rd;
        source_t           src_a;
        source_t           src_b;
        logic [`TAG_W-1:0] dest_tag;
    } instruction_t;

    // Retiring entry, seen by the register file and the bypass
    typedef struct packed {
        logic              we;
        logic [`REG_W-1:0] rd;
        logic [`TAG_W-1:0] tag;
        logic [`XLEN-1:0]  data;
    } commit_port_t;

    // New speculative mapping rd -> tag
    typedef struct packed {
        logic              we;
        logic [`REG_W-1:0] rd;
        logic [`TAG_W-1:0] tag;
    } map_write_t;

    // Bypass view of one reorder buffer entry
    typedef struct packed {
        logic             valid;
        logic             ready;
        logic [`XLEN-1:0] result;
    } rob_view_t;

endpackage

// File: verilog/rename_ifs.sv
`timescale 1ns/10ps
`include "rename_defs.svh"

// ---------------------------------------------------------------------
// Map reads and map writes between rename and the register file
// ---------------------------------------------------------------------
interface rat_if;
    logic [`REG_W-1:0]      rd_idx_a [`PIPE_WIDTH];
    logic [`REG_W-1:0]      rd_idx_b [`PIPE_WIDTH];
    rename_pkg::source_t    rd_src_a [`PIPE_WIDTH];
    rename_pkg::source_t    rd_src_b [`PIPE_WIDTH];
    rename_pkg::map_write_t map_wr   [`PIPE_WIDTH];

    modport ren  (output rd_idx_a, rd_idx_b, map_wr, input rd_src_a, rd_src_b);
    modport regs (input rd_idx_a, rd_idx_b, map_wr, output rd_src_a, rd_src_b);
endinterface

// ---------------------------------------------------------------------
// Tag allocation and bypass view between rename and the reorder buffer
// ---------------------------------------------------------------------
interface rob_if (
    input logic clk,
    input logic rst_n
);
    // Registered room flags, independent of any request
    logic                  free_one;
    logic                  free_two;
    logic [`TAG_W-1:0]     alloc_tag  [`PIPE_WIDTH];
    logic [`PIPE_WIDTH-1:0] alloc_take;
    // Destination kept per entry for commit, zero when none
    logic [`REG_W-1:0]     alloc_rd   [`PIPE_WIDTH];
    rename_pkg::rob_view_t view       [`ROB_ENTRIES];

    modport ren (input clk, rst_n, free_one, free_two, alloc_tag, view,
                 output alloc_take, alloc_rd);
    modport rob (input alloc_take, alloc_rd,
                 output free_one, free_two, alloc_tag, view);
endinterface

// File: verilog/prf.sv
`timescale 1ns/10ps
`include "rename_defs.svh"

module prf (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    rat_if.regs                      rat,
    input  rename_pkg::commit_port_t commit [`PIPE_WIDTH]
);

    // Committed values, renamed flags and producer tags
    logic [`XLEN-1:0]      value_q [`ARCH_REGS];
    logic [`ARCH_REGS-1:0] renamed_q;
    logic [`TAG_W-1:0]     tag_q   [`ARCH_REGS];

    // ---------------------------------------------------------------------
    // Read ports, tag view while renamed, value otherwise
    // ---------------------------------------------------------------------
    always_comb begin
        for (int s = 0; s < `PIPE_WIDTH; s++) begin
            rat.rd_src_a[s] = '0;
            rat.rd_src_a[s].reg_idx = rat.rd_idx_a[s];
            rat.rd_src_a[s].renamed = renamed_q[rat.rd_idx_a[s]];
            if (renamed_q[rat.rd_idx_a[s]])
                rat.rd_src_a[s].operand.tag_view.tag = tag_q[rat.rd_idx_a[s]];
            else
                rat.rd_src_a[s].operand.value = value_q[rat.rd_idx_a[s]];

            rat.rd_src_b[s] = '0;
            rat.rd_src_b[s].reg_idx = rat.rd_idx_b[s];
            rat.rd_src_b[s].renamed = renamed_q[rat.rd_idx_b[s]];
            if (renamed_q[rat.rd_idx_b[s]])
                rat.rd_src_b[s].operand.tag_view.tag = tag_q[rat.rd_idx_b[s]];
            else
                rat.rd_src_b[s].operand.value = value_q[rat.rd_idx_b[s]];
        end
    end

    // ---------------------------------------------------------------------
    // Commit writes first, then map writes, so a newer mapping survives
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            renamed_q <= '0;
            for (int r = 0; r < `ARCH_REGS; r++)
                value_q[r] <= '0;
        end else begin
            for (int c = 0; c < `PIPE_WIDTH; c++) begin
                // x0 stays zero
                if (commit[c].we && commit[c].rd != '0) begin
                    value_q[commit[c].rd] <= commit[c].data;
                    // Only drop the mapping if it still points at this producer
                    if (tag_q[commit[c].rd] == commit[c].tag)
                        renamed_q[commit[c].rd] <= 1'b0;
                end
            end
            if (flush) begin
                renamed_q <= '0;
            end else begin
                // Slot 1 last, younger write to the same rd wins
                for (int s = 0; s < `PIPE_WIDTH; s++)
                    if (rat.map_wr[s].we)
                        renamed_q[rat.map_wr[s].rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < `PIPE_WIDTH; s++)
            if (rat.map_wr[s].we && !flush)
                tag_q[rat.map_wr[s].rd] <= rat.map_wr[s].tag;
    end

    // Rename must never map x0
    for (genvar s = 0; s < `PIPE_WIDTH; s++) begin : g_chk
        a_no_x0_map: assert property (@(posedge clk) disable iff (!rst_n)
            rat.map_wr[s].we |-> (rat.map_wr[s].rd != '0))
            else $error("map write to x0 on slot %0d", s);
    end

endmodule

// File: verilog/rob.sv
`timescale 1ns/10ps
`include "rename_defs.svh"

module rob (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     flush,
    rob_if.rob                       alloc,
    input  logic                     wb_valid,
    input  logic [`TAG_W-1:0]        wb_tag,
    input  logic [`XLEN-1:0]         wb_data,
    output rename_pkg::commit_port_t commit [`PIPE_WIDTH]
);

    logic [`TAG_W-1:0]       head_q;
    logic [`TAG_W-1:0]       tail_q;
    // One extra bit, count reaches ROB_ENTRIES when full
    logic [`TAG_W:0]         count_q;
    logic [`TAG_W:0]         count_d;
    logic [`ROB_ENTRIES-1:0] valid_q;
    logic [`ROB_ENTRIES-1:0] ready_q;
    logic [`REG_W-1:0]       rd_q     [`ROB_ENTRIES];
    logic [`XLEN-1:0]        result_q [`ROB_ENTRIES];
    logic                    free_one_q;
    logic                    free_two_q;
    logic [1:0]              n_alloc;
    logic [1:0]              n_commit;

    // ---------------------------------------------------------------------
    // Allocation, tail first, slot 1 skips past a taken slot 0
    // ---------------------------------------------------------------------
    assign alloc.alloc_tag[0] = tail_q;
    assign alloc.alloc_tag[1] = tail_q + {{(`TAG_W-1){1'b0}}, alloc.alloc_take[0]};
    assign alloc.free_one     = free_one_q;
    assign alloc.free_two     = free_two_q;

    // Entry state as seen by the rename bypass
    always_comb begin
        for (int e = 0; e < `ROB_ENTRIES; e++) begin
            alloc.view[e].valid  = valid_q[e];
            alloc.view[e].ready  = ready_q[e];
            alloc.view[e].result = result_q[e];
        end
    end

    // In-order commit, slot 1 only behind a committing slot 0
    always_comb begin
        logic ok;
        ok = 1'b1;
        for (int c = 0; c < `PIPE_WIDTH; c++) begin
            commit[c].tag  = head_q + c[`TAG_W-1:0];
            ok             = ok && valid_q[commit[c].tag] && ready_q[commit[c].tag];
            commit[c].we   = ok;
            commit[c].rd   = rd_q[commit[c].tag];
            commit[c].data = result_q[commit[c].tag];
        end
    end

    always_comb begin
        n_alloc  = '0;
        n_commit = '0;
        for (int s = 0; s < `PIPE_WIDTH; s++) begin
            n_alloc  = n_alloc + {1'b0, alloc.alloc_take[s]};
            n_commit = n_commit + {1'b0, commit[s].we};
        end
        if (flush)
            count_d = '0;
        else
            count_d = count_q + {{(`TAG_W-1){1'b0}}, n_alloc}
                              - {{(`TAG_W-1){1'b0}}, n_commit};
    end

    // ---------------------------------------------------------------------
    // Pointers, flags and per-entry control
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_q     <= '0;
            tail_q     <= '0;
            count_q    <= '0;
            valid_q    <= '0;
            ready_q    <= '0;
            free_one_q <= 1'b1;
            free_two_q <= 1'b1;
        end else begin
            count_q    <= count_d;
            free_one_q <= (count_d <= `ROB_ENTRIES - 1);
            free_two_q <= (count_d <= `ROB_ENTRIES - 2);
            if (flush) begin
                head_q  <= '0;
                tail_q  <= '0;
                valid_q <= '0;
            end else begin
                head_q <= head_q + {{(`TAG_W-2){1'b0}}, n_commit};
                tail_q <= tail_q + {{(`TAG_W-2){1'b0}}, n_alloc};
                for (int c = 0; c < `PIPE_WIDTH; c++)
                    if (commit[c].we)
                        valid_q[commit[c].tag] <= 1'b0;
                for (int s = 0; s < `PIPE_WIDTH; s++) begin
                    if (alloc.alloc_take[s]) begin
                        valid_q[alloc.alloc_tag[s]] <= 1'b1;
                        ready_q[alloc.alloc_tag[s]] <= 1'b0;
                    end
                end
                // Result shows in the view from the next cycle
                if (wb_valid)
                    ready_q[wb_tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < `PIPE_WIDTH; s++)
            if (alloc.alloc_take[s])
                rd_q[alloc.alloc_tag[s]] <= alloc.alloc_rd[s];
        if (wb_valid)
            result_q[wb_tag] <= wb_data;
    end

    // Rename only takes what the registered flags offered
    a_take_one: assert property (@(posedge clk) disable iff (!rst_n)
        (|alloc.alloc_take) |-> alloc.free_one)
        else $error("allocation with no free entry");
    a_take_two: assert property (@(posedge clk) disable iff (!rst_n)
        (&alloc.alloc_take) |-> alloc.free_two)
        else $error("double allocation with one free entry");
    // Writeback from outside must hit a live, pending entry
    a_wb_live: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> (valid_q[wb_tag] && !ready_q[wb_tag]))
        else $error("writeback to tag %0d not pending", wb_tag);

endmodule

// File: verilog/rename.sv
`timescale 1ns/10ps
`include "rename_defs.svh"

module rename (
    rat_if.ren                       rat,
    rob_if.ren                       rob,
    input  rename_pkg::commit_port_t commit [`PIPE_WIDTH],
    input  rename_pkg::instruction_t dec    [`PIPE_WIDTH],
    input  logic                     disp_ready,
    output logic                     rename_ready,
    output rename_pkg::instruction_t ren    [`PIPE_WIDTH]
);

    rename_pkg::instruction_t built [`PIPE_WIDTH];
    rename_pkg::instruction_t fwd   [`PIPE_WIDTH];
    rename_pkg::instruction_t cmp   [`PIPE_WIDTH];
    logic [1:0]               n_valid;
    logic                     room;
    logic                     fire;

    // ---------------------------------------------------------------------
    // Source fix-ups
    // ---------------------------------------------------------------------

    // Slot 0 writes a register slot 1 reads, take slot 0's tag
    function automatic rename_pkg::source_t fwd_src(
        input rename_pkg::source_t      src,
        input rename_pkg::instruction_t prod
    );
        rename_pkg::source_t res;
        res = src;
        if (prod.valid && prod.has_rd && prod.rd != '0 && src.reg_idx == prod.rd) begin
            res.renamed                = 1'b1;
            res.operand.tag_view.pad   = '0;
            res.operand.tag_view.tag   = prod.dest_tag;
        end
        return res;
    endfunction

    // Producer done but not retired, read its result out of the ROB
    function automatic rename_pkg::source_t rob_bypass(
        input rename_pkg::source_t   src,
        input rename_pkg::rob_view_t view [`ROB_ENTRIES]
    );
        rename_pkg::source_t   res;
        rename_pkg::rob_view_t ent;
        res = src;
        ent = view[src.operand.tag_view.tag];
        if (src.renamed && ent.valid && ent.ready) begin
            res.renamed       = 1'b0;
            res.operand.value = ent.result;
        end
        return res;
    endfunction

    // Producer retiring this cycle
    function automatic rename_pkg::source_t commit_bypass(
        input rename_pkg::source_t      src,
        input rename_pkg::commit_port_t ports [`PIPE_WIDTH]
    );
        rename_pkg::source_t res;
        res = src;
        for (int c = 0; c < `PIPE_WIDTH; c++) begin
            if (src.renamed && ports[c].we && ports[c].tag == src.operand.tag_view.tag) begin
                res.renamed       = 1'b0;
                res.operand.value = ports[c].data;
            end
        end
        return res;
    endfunction

    // ---------------------------------------------------------------------
    // Handshake
    // ---------------------------------------------------------------------
    always_comb begin
        n_valid = '0;
        for (int s = 0; s < `PIPE_WIDTH; s++)
            n_valid = n_valid + {1'b0, dec[s].valid};
    end

    // Room for the valid slot count, an empty group always fits
    assign room         = (n_valid == 2'd2) ? rob.free_two : (n_valid == 2'd0 || rob.free_one);
    assign rename_ready = disp_ready && room;
    assign fire         = rename_ready && (n_valid != 2'd0);

    // Map reads, tag takes and map writes per slot
    always_comb begin
        for (int s = 0; s < `PIPE_WIDTH; s++) begin
            rat.rd_idx_a[s]      = dec[s].src_a.reg_idx;
            rat.rd_idx_b[s]      = dec[s].src_b.reg_idx;
            rob.alloc_take[s]    = dec[s].valid && fire;
            rob.alloc_rd[s]      = dec[s].has_rd ? dec[s].rd : '0;
            rat.map_wr[s].we     = dec[s].valid && fire && dec[s].has_rd && dec[s].rd != '0;
            rat.map_wr[s].rd     = dec[s].rd;
            rat.map_wr[s].tag    = rob.alloc_tag[s];
        end
    end

    // ---------------------------------------------------------------------
    // Rename datapath
    // ---------------------------------------------------------------------
    always_comb begin
        // Map read results plus the new tag
        for (int s = 0; s < `PIPE_WIDTH; s++) begin
            built[s]          = dec[s];
            built[s].valid    = dec[s].valid && fire;
            built[s].src_a    = rat.rd_src_a[s];
            built[s].src_b    = rat.rd_src_b[s];
            built[s].dest_tag = rob.alloc_tag[s];
        end

        // Intra-group dependency, x0 skipped inside fwd_src
        fwd          = built;
        fwd[1].src_a = fwd_src(built[1].src_a, built[0]);
        fwd[1].src_b = fwd_src(built[1].src_b, built[0]);

        // Lone slot 1 moves down to slot 0
        if (!fwd[0].valid && fwd[1].valid) begin
            cmp[0] = fwd[1];
            cmp[1] = '0;
        end else begin
            cmp = fwd;
        end

        // ROB bypass, then commit bypass
        for (int s = 0; s < `PIPE_WIDTH; s++) begin
            ren[s]       = cmp[s];
            ren[s].src_a = commit_bypass(rob_bypass(cmp[s].src_a, rob.view), commit);
            ren[s].src_b = commit_bypass(rob_bypass(cmp[s].src_b, rob.view), commit);
        end
    end

    a_compact: assert property (@(posedge rob.clk) disable iff (!rob.rst_n)
        ren[1].valid |-> ren[0].valid)
        else $error("slot 1 valid without slot 0");

endmodule

// File: verilog/rename_top.sv
`timescale 1ns/10ps
`include "rename_defs.svh"

module rename_top (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    flush,
    // Decode side, one entry per slot
    input  logic [`PIPE_WIDTH-1:0]                  dec_valid,
    input  logic [`PIPE_WIDTH-1:0][`XLEN-1:0]       dec_pc,
    input  logic [`PIPE_WIDTH-1:0][`REG_W-1:0]      dec_rd,
    input  logic [`PIPE_WIDTH-1:0]                  dec_has_rd,
    input  logic [`PIPE_WIDTH-1:0][`REG_W-1:0]      dec_rs1,
    input  logic [`PIPE_WIDTH-1:0][`REG_W-1:0]      dec_rs2,
    output logic                                    rename_ready,
    // Dispatch side
    input  logic                                    disp_ready,
    output logic [`PIPE_WIDTH-1:0]                  ren_valid,
    output logic [`PIPE_WIDTH-1:0][`TAG_W-1:0]      ren_dest_tag,
    output logic [`PIPE_WIDTH-1:0]                  ren_a_renamed,
    output logic [`PIPE_WIDTH-1:0][`XLEN-1:0]       ren_a_word,
    output logic [`PIPE_WIDTH-1:0]                  ren_b_renamed,
    output logic [`PIPE_WIDTH-1:0][`XLEN-1:0]       ren_b_word,
    // Writeback, one result per cycle
    input  logic                                    wb_valid,
    input  logic [`TAG_W-1:0]                       wb_tag,
    input  logic [`XLEN-1:0]                        wb_data,
    // Retirement
    output logic [`PIPE_WIDTH-1:0]                  commit_valid,
    output logic [`PIPE_WIDTH-1:0][`REG_W-1:0]      commit_rd,
    output logic [`PIPE_WIDTH-1:0][`XLEN-1:0]       commit_data
);

    rename_pkg::commit_port_t commit [`PIPE_WIDTH];
    rename_pkg::instruction_t dec    [`PIPE_WIDTH];
    rename_pkg::instruction_t ren    [`PIPE_WIDTH];

    rat_if u_rat_if ();
    rob_if u_rob_if (.clk(clk), .rst_n(rst_n));

    // ---------------------------------------------------------------------
    // Port packing per slot
    // ---------------------------------------------------------------------
    for (genvar s = 0; s < `PIPE_WIDTH; s++) begin : g_slot
        assign dec[s] = '{valid: dec_valid[s], pc: dec_pc[s], rd: dec_rd[s],
                          has_rd: dec_has_rd[s],
                          src_a: '{reg_idx: dec_rs1[s], renamed: 1'b0, operand: '0},
                          src_b: '{reg_idx: dec_rs2[s], renamed: 1'b0, operand: '0},
                          dest_tag: '0};

        assign ren_valid[s]     = ren[s].valid;
        assign ren_dest_tag[s]  = ren[s].dest_tag;
        assign ren_a_renamed[s] = ren[s].src_a.renamed;
        assign ren_a_word[s]    = ren[s].src_a.operand.value;
        assign ren_b_renamed[s] = ren[s].src_b.renamed;
        assign ren_b_word[s]    = ren[s].src_b.operand.value;

        assign commit_valid[s]  = commit[s].we;
        assign commit_rd[s]     = commit[s].rd;
        assign commit_data[s]   = commit[s].data;
    end

    prf u_prf (
        .clk    (clk),
        .rst_n  (rst_n),
        .flush  (flush),
        .rat    (u_rat_if.regs),
        .commit (commit)
    );

    rob u_rob (
        .clk      (clk),
        .rst_n    (rst_n),
        .flush    (flush),
        .alloc    (u_rob_if.rob),
        .wb_valid (wb_valid),
        .wb_tag   (wb_tag),
        .wb_data  (wb_data),
        .commit   (commit)
    );

    rename u_rename (
        .rat          (u_rat_if.ren),
        .rob          (u_rob_if.ren),
        .commit       (commit),
        .dec          (dec),
        .disp_ready   (disp_ready),
        .rename_ready (rename_ready),
        .ren          (ren)
    );

endmodule

// File: testbench/tb_rename_top.sv
`timescale 1ns/10ps
`include "rename_defs.svh"

module tb_rename_top;

    localparam int N_GROUPS         = 500;
    // Worst case per group with stalls, full buffer and drains
    localparam int CYCLES_PER_GROUP = 12;
    localparam int TIMEOUT_CYCLES   = N_GROUPS * CYCLES_PER_GROUP;
    // Two register sweeps, one lone slot 1 group and the fill sequence
    localparam int N_RANDOM         = N_GROUPS - 26;
    localparam int MAX_SEQ          = 2048;

    logic                               clk;
    logic                               rst_n;
    logic                               flush;
    logic [`PIPE_WIDTH-1:0]             dec_valid;
    logic [`PIPE_WIDTH-1:0][`XLEN-1:0]  dec_pc;
    logic [`PIPE_WIDTH-1:0][`REG_W-1:0] dec_rd;
    logic [`PIPE_WIDTH-1:0]             dec_has_rd;
    logic [`PIPE_WIDTH-1:0][`REG_W-1:0] dec_rs1;
    logic [`PIPE_WIDTH-1:0][`REG_W-1:0] dec_rs2;
    logic                               rename_ready;
    logic                               disp_ready;
    logic [`PIPE_WIDTH-1:0]             ren_valid;
    logic [`PIPE_WIDTH-1:0][`TAG_W-1:0] ren_dest_tag;
    logic [`PIPE_WIDTH-1:0]             ren_a_renamed;
    logic [`PIPE_WIDTH-1:0][`XLEN-1:0]  ren_a_word;
    logic [`PIPE_WIDTH-1:0]             ren_b_renamed;
    logic [`PIPE_WIDTH-1:0][`XLEN-1:0]  ren_b_word;
    logic                               wb_valid;
    logic [`TAG_W-1:0]                  wb_tag;
    logic [`XLEN-1:0]                   wb_data;
    logic [`PIPE_WIDTH-1:0]             commit_valid;
    logic [`PIPE_WIDTH-1:0][`REG_W-1:0] commit_rd;
    logic [`PIPE_WIDTH-1:0][`XLEN-1:0]  commit_data;

    // Reference model state
    // Per register, pending producer or known value
    logic              map_pend [`ARCH_REGS];
    int                map_seq  [`ARCH_REGS];
    logic [`XLEN-1:0]  map_val  [`ARCH_REGS];
    logic [`XLEN-1:0]  arch_val [`ARCH_REGS];
    // Per instruction in allocation order
    logic [`TAG_W-1:0] seq_tag  [MAX_SEQ];
    logic [`REG_W-1:0] seq_rd   [MAX_SEQ];
    logic              seq_done [MAX_SEQ];
    logic [`XLEN-1:0]  seq_data [MAX_SEQ];
    int                next_seq;
    logic [`TAG_W-1:0] next_tag;
    // Allocated but not written back, allocated but not committed
    int                pend_q   [$];
    int                commit_q [$];

    integer            seed;
    int                wb_seq;
    logic              wb_enable;
    logic [1:0]        vmask;
    int                cycle_count;

    rename_top u_dut (.*);

    always #5 clk = ~clk;

    // ------------------------------------------------------------------
    // Checking helpers
    // ------------------------------------------------------------------
    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    // Expected source as {renamed, operand word}
    function automatic logic [`XLEN:0] expected_source(
        input logic [`REG_W-1:0] src,
        input logic              fwd_ok,
        input logic [`REG_W-1:0] fwd_rd,
        input logic [`TAG_W-1:0] fwd_tag
    );
        logic [`XLEN:0] res;
        if (fwd_ok && fwd_rd == src && src != '0)
            res = {1'b1, {(`XLEN-`TAG_W){1'b0}}, fwd_tag};
        else if (map_pend[src] && !seq_done[map_seq[src]])
            res = {1'b1, {(`XLEN-`TAG_W){1'b0}}, seq_tag[map_seq[src]]};
        else if (map_pend[src])
            // Done, committing or retired all give the written data
            res = {1'b0, seq_data[map_seq[src]]};
        else
            res = {1'b0, map_val[src]};
        return res;
    endfunction

    // Handshake and renamed group, against the state before this edge
    task automatic check_group();
        int             nv;
        int             o;
        logic           room;
        logic           fire;
        logic           fwd_ok;
        logic [`XLEN:0] ea;
        logic [`XLEN:0] eb;
        nv   = dec_valid[0] + dec_valid[1];
        room = (nv == 2) ? (commit_q.size() <= `ROB_ENTRIES - 2)
                         : (nv == 0 || commit_q.size() <= `ROB_ENTRIES - 1);
        fire = disp_ready && room && nv != 0;
        check_value("rename_ready", rename_ready, disp_ready && room);
        check_value("ren_valid", ren_valid, !fire ? 2'b00 : (nv == 2 ? 2'b11 : 2'b01));
        if (fire) begin
            o      = 0;
            fwd_ok = 1'b0;
            for (int s = 0; s < `PIPE_WIDTH; s++) begin
                if (dec_valid[s]) begin
                    ea = expected_source(dec_rs1[s], fwd_ok, dec_rd[0], seq_tag[next_seq - 1]);
                    eb = expected_source(dec_rs2[s], fwd_ok, dec_rd[0], seq_tag[next_seq - 1]);
                    check_value($sformatf("ren_dest_tag[%0d]", o), ren_dest_tag[o], next_tag);
                    check_value($sformatf("ren_a_renamed[%0d]", o), ren_a_renamed[o], ea[`XLEN]);
                    check_value($sformatf("ren_a_word[%0d]", o), ren_a_word[o], ea[`XLEN-1:0]);
                    check_value($sformatf("ren_b_renamed[%0d]", o), ren_b_renamed[o], eb[`XLEN]);
                    check_value($sformatf("ren_b_word[%0d]", o), ren_b_word[o], eb[`XLEN-1:0]);
                    // Allocate and map
                    seq_tag[next_seq]  = next_tag;
                    seq_rd[next_seq]   = dec_has_rd[s] ? dec_rd[s] : '0;
                    seq_done[next_seq] = 1'b0;
                    pend_q.push_back(next_seq);
                    commit_q.push_back(next_seq);
                    if (dec_has_rd[s] && dec_rd[s] != '0) begin
                        map_pend[dec_rd[s]] = 1'b1;
                        map_seq[dec_rd[s]]  = next_seq;
                    end
                    // Only a valid slot 0 forwards into slot 1
                    fwd_ok   = (s == 0) && dec_has_rd[0];
                    next_seq = next_seq + 1;
                    next_tag = next_tag + 1'b1;
                    o        = o + 1;
                end
            end
        end
    endtask

    // Commits leave in allocation order
    task automatic check_commits();
        int seq;
        for (int c = 0; c < `PIPE_WIDTH; c++) begin
            if (commit_valid[c]) begin
                if (commit_q.size() == 0) begin
                    $display("Commit seen with no instruction outstanding");
                    abort_run();
                end else begin
                    seq = commit_q.pop_front();
                    if (!seq_done[seq]) begin
                        $display("Commit of an instruction that never wrote back");
                        abort_run();
                    end
                    check_value($sformatf("commit_rd[%0d]", c), commit_rd[c], seq_rd[seq]);
                    check_value($sformatf("commit_data[%0d]", c), commit_data[c], seq_data[seq]);
                    if (seq_rd[seq] != '0)
                        arch_val[seq_rd[seq]] = seq_data[seq];
                end
            end
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            check_group();
            check_commits();
            // Result visible to rename from the next cycle
            if (wb_valid) begin
                seq_done[wb_seq] = 1'b1;
                seq_data[wb_seq] = wb_data;
            end
            if (flush) begin
                for (int r = 0; r < `ARCH_REGS; r++) begin
                    map_pend[r] = 1'b0;
                    map_val[r]  = arch_val[r];
                end
                pend_q.delete();
                commit_q.delete();
                next_tag = '0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the run did not complete", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // ------------------------------------------------------------------
    // Stimulus, all driven on the falling edge
    // ------------------------------------------------------------------
    task automatic drive_writeback();
        int idx;
        wb_valid = 1'b0;
        if (wb_enable && pend_q.size() != 0 && ($random(seed) & 3) != 0) begin
            idx = ($random(seed) & 32'h7fff_ffff) % pend_q.size();
            wb_seq = pend_q[idx];
            pend_q.delete(idx);
            wb_valid = 1'b1;
            wb_tag   = seq_tag[wb_seq];
            wb_data  = $random(seed);
        end
    endtask

    task automatic drive_random_group(input logic [1:0] mask);
        dec_valid = mask;
        for (int s = 0; s < `PIPE_WIDTH; s++) begin
            dec_pc[s]     = $random(seed);
            // Few registers, so slots and groups collide often
            dec_rd[s]     = $random(seed) & 7;
            dec_has_rd[s] = ($random(seed) & 3) != 0;
            dec_rs1[s]    = $random(seed) & 7;
            dec_rs2[s]    = $random(seed) & 7;
        end
    endtask

    // Decode holds its group until it fires
    task automatic hold_until_fired(input logic stall);
        logic done;
        done = 1'b0;
        while (!done) begin
            drive_writeback();
            disp_ready = stall ? (($random(seed) & 3) != 0) : 1'b1;
            @(posedge clk);
            done = rename_ready && (dec_valid != '0);
            @(negedge clk);
        end
        dec_valid = '0;
    endtask

    task automatic drain_rob();
        dec_valid = '0;
        while (commit_q.size() != 0) begin
            drive_writeback();
            @(posedge clk);
            @(negedge clk);
        end
    endtask

    task automatic flush_pipeline();
        dec_valid = '0;
        wb_valid  = 1'b0;
        flush     = 1'b1;
        @(posedge clk);
        @(negedge clk);
        flush     = 1'b0;
    endtask

    // Four sources per group, no destinations
    task automatic read_all_regs();
        for (int k = 0; k < `ARCH_REGS / 4; k++) begin
            dec_valid  = 2'b11;
            dec_has_rd = 2'b00;
            dec_rd     = '0;
            dec_rs1[0] = 4 * k;
            dec_rs2[0] = 4 * k + 1;
            dec_rs1[1] = 4 * k + 2;
            dec_rs2[1] = 4 * k + 3;
            hold_until_fired(1'b0);
        end
    endtask

    // Withheld writebacks, buffer fills and the next group waits
    task automatic fill_rob();
        wb_enable = 1'b0;
        for (int g = 0; g < `ROB_ENTRIES / 2; g++) begin
            drive_random_group(2'b11);
            hold_until_fired(1'b0);
        end
        drive_random_group(2'b01);
        for (int c = 0; c < 4; c++) begin
            drive_writeback();
            @(posedge clk);
            check_value("rename_ready", rename_ready, 1'b0);
            @(negedge clk);
        end
        wb_enable = 1'b1;
        hold_until_fired(1'b0);
    endtask

    initial begin
        seed        = 32'hd92c;
        clk         = 1'b0;
        rst_n       = 1'b0;
        flush       = 1'b0;
        dec_valid   = '0;
        dec_pc      = '0;
        dec_rd      = '0;
        dec_has_rd  = '0;
        dec_rs1     = '0;
        dec_rs2     = '0;
        disp_ready  = 1'b1;
        wb_valid    = 1'b0;
        wb_tag      = '0;
        wb_data     = '0;
        wb_seq      = 0;
        wb_enable   = 1'b1;
        next_seq    = 0;
        next_tag    = '0;
        cycle_count = 0;
        for (int r = 0; r < `ARCH_REGS; r++) begin
            map_pend[r] = 1'b0;
            map_seq[r]  = 0;
            map_val[r]  = '0;
            arch_val[r] = '0;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Everything reads zero after reset
        read_all_regs();
        // Lone slot 1 comes out in slot 0
        drive_random_group(2'b10);
        hold_until_fired(1'b0);
        drain_rob();
        fill_rob();
        drain_rob();

        for (int g = 0; g < N_RANDOM; g++) begin
            vmask = $random(seed) & 3;
            if (vmask == 2'b00)
                vmask = 2'b11;
            drive_random_group(vmask);
            hold_until_fired(1'b1);
            // Mid-run flush, then committed values only
            if (g == N_RANDOM / 2) begin
                flush_pipeline();
                read_all_regs();
            end
        end
        drain_rob();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: rename_core.f
+incdir+verilog
verilog/rename_pkg.sv
verilog/rename_ifs.sv
verilog/prf.sv
verilog/rob.sv
verilog/rename.sv
verilog/rename_top.sv
testbench/tb_rename_top.sv
